//--- verilog/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // Datapath width shared by operands, results and both arithmetic units
    localparam int calc_w = 16;

    // Operands wrap modulo 2^16 but are shown as signed
    typedef logic signed [calc_w-1:0] calc_word_t;

    typedef enum logic [1:0] {
        OP_ADD = 2'b00,   // Keypad code 001
        OP_SUB = 2'b01,   // Keypad code 010
        OP_MUL = 2'b10    // Keypad code 100
    } calc_op_e;

    typedef enum logic [2:0] {
        ENTER_FIRST  = 3'b000,  // Accumulating first operand
        ENTER_SECOND = 3'b001,  // Accumulating second operand
        DISPATCH     = 3'b010,  // Request registered toward one unit
        WAIT_UNIT    = 3'b011,  // Waiting on the selected unit's done
        SHOW         = 3'b100   // Result latched, complete high
    } calc_state_e;

    // Controller to unit, 35 bits
    typedef struct packed {
        logic       start;  // One-cycle strobe
        calc_op_e   op;
        calc_word_t a;      // First operand or multiplicand
        calc_word_t b;      // Second operand or multiplier
    } arith_req_t;

    // Unit to controller, 17 bits
    typedef struct packed {
        logic       done;   // One-cycle strobe
        calc_word_t value;  // Valid while done is high
    } arith_resp_t;

endpackage

`default_nettype wire

//--- verilog/add_sub_unit.sv
`timescale 1ns/1ps
`default_nettype none

module add_sub_unit (
    input  logic                 clk,
    input  logic                 nRST,
    input  calc_pkg::arith_req_t  req,
    output calc_pkg::arith_resp_t resp
);
    import calc_pkg::*;

    logic       done_q;     // Pulses the cycle after start
    calc_word_t value_q;
    calc_word_t sum;

    // Two's-complement add or subtract, wraps in 16 bits
    always_comb begin
        case (req.op)
            OP_SUB:  sum = req.a - req.b;
            default: sum = req.a + req.b;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            done_q <= 1'b0;
        end else begin
            done_q <= req.start;
        end
    end

    // Result register holds until the next start
    always_ff @(posedge clk) begin
        if (req.start) begin
            value_q <= sum;
        end
    end

    assign resp = '{done: done_q, value: value_q};

endmodule

`default_nettype wire

//--- verilog/shift_add_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
    input  logic                 clk,
    input  logic                 nRST,
    input  calc_pkg::arith_req_t  req,
    output calc_pkg::arith_resp_t resp
);
    import calc_pkg::*;

    localparam int step_w = $clog2(calc_w);

    // Control
    logic              busy;
    logic [step_w-1:0] step;      // Partial products taken so far
    logic              done_q;
    logic              last_step;

    // Datapath
    calc_word_t        mcand;     // Shifted left each step
    logic [calc_w-1:0] mplier;    // Shifted right each step
    logic [calc_w-1:0] mplier_next;
    calc_word_t        acc;
    calc_word_t        acc_next;
    calc_word_t        value_q;

    always_comb begin
        acc_next    = mplier[0] ? acc + mcand : acc;
        mplier_next = mplier >> 1;
        // Early exit once no multiplier bits remain
        last_step   = (mplier_next == '0) || (step == step_w'(calc_w - 1));
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (req.start && !busy) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + step_w'(1);
                if (last_step) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // Operands and accumulator; the op field plays no part here
    always_ff @(posedge clk) begin
        if (req.start && !busy) begin
            mcand  <= req.a;
            mplier <= req.b;
            acc    <= '0;
        end else if (busy) begin
            acc    <= acc_next;
            mcand  <= mcand << 1;
            mplier <= mplier_next;
            if (last_step) begin
                value_q <= acc_next;  // Low 16 bits of the product
            end
        end
    end

    assign resp = '{done: done_q, value: value_q};

endmodule

`default_nettype wire

//--- verilog/calc_controller.sv
`timescale 1ns/1ps
`default_nettype none

module calc_controller (
    input  logic                  clk,
    input  logic                  nRST,
    input  logic [3:0]            digit,
    input  logic                  digit_valid,
    input  logic [2:0]            operator_code,
    input  logic                  equal,
    output calc_pkg::arith_req_t  addsub_req,
    output calc_pkg::arith_req_t  mul_req,
    input  calc_pkg::arith_resp_t addsub_resp,
    input  calc_pkg::arith_resp_t mul_resp,
    output logic                  complete,
    output calc_pkg::calc_word_t  display_value
);
    import calc_pkg::*;

    calc_state_e state;
    calc_state_e next_state;

    calc_word_t  operand_a;
    calc_word_t  operand_b;
    calc_op_e    op_q;        // Operator latched in ENTER_FIRST
    calc_op_e    op_dec;
    logic        op_ok;       // Exactly one valid one-hot code
    logic        digit_ok;
    logic        sel_mul;     // Unit that was dispatched to
    logic        unit_done;

    // Operand times ten plus the new digit, modulo 2^16
    function automatic calc_word_t push_digit(input calc_word_t cur, input logic [3:0] d);
        calc_word_t times_ten;
        times_ten = (cur << 3) + (cur << 1);
        return times_ten + calc_word_t'({{(calc_w - 4){1'b0}}, d});
    endfunction

    assign digit_ok  = digit_valid && (digit <= 4'd9);
    assign unit_done = sel_mul ? mul_resp.done : addsub_resp.done;

    always_comb begin
        op_ok  = 1'b1;
        op_dec = OP_ADD;
        case (operator_code)
            3'b001:  op_dec = OP_ADD;
            3'b010:  op_dec = OP_SUB;
            3'b100:  op_dec = OP_MUL;
            default: op_ok  = 1'b0;   // Zero or several bits set
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            ENTER_FIRST: begin
                if (op_ok) begin
                    next_state = ENTER_SECOND;
                end
            end
            ENTER_SECOND: begin
                if (equal) begin
                    next_state = DISPATCH;
                end
            end
            DISPATCH: next_state = WAIT_UNIT;
            WAIT_UNIT: begin
                if (unit_done) begin
                    next_state = SHOW;
                end
            end
            SHOW:     next_state = ENTER_FIRST;
            default:  next_state = ENTER_FIRST;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ENTER_FIRST;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand_a     <= '0;
            operand_b     <= '0;
            op_q          <= OP_ADD;
            sel_mul       <= 1'b0;
            addsub_req    <= '0;
            mul_req       <= '0;
            complete      <= 1'b0;
            display_value <= '0;
        end else begin
            // Strobes default low
            addsub_req.start <= 1'b0;
            mul_req.start    <= 1'b0;
            complete         <= 1'b0;

            case (state)
                ENTER_FIRST: begin
                    if (digit_ok) begin
                        operand_a <= push_digit(operand_a, digit);
                    end
                    if (op_ok) begin
                        op_q <= op_dec;
                    end
                end
                ENTER_SECOND: begin
                    if (digit_ok) begin
                        operand_b <= push_digit(operand_b, digit);
                    end
                end
                DISPATCH: begin
                    sel_mul <= (op_q == OP_MUL);
                    if (op_q == OP_MUL) begin
                        mul_req <= '{start: 1'b1, op: op_q, a: operand_a, b: operand_b};
                    end else begin
                        addsub_req <= '{start: 1'b1, op: op_q, a: operand_a, b: operand_b};
                    end
                end
                WAIT_UNIT: begin
                    if (unit_done) begin
                        display_value <= sel_mul ? mul_resp.value : addsub_resp.value;
                        complete      <= 1'b1;
                    end
                end
                SHOW: begin
                    operand_a <= '0;   // Fresh entry for the next calculation
                    operand_b <= '0;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/calc_top.sv
`timescale 1ns/1ps
`default_nettype none

module calc_top (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [3:0]           digit,
    input  logic                 digit_valid,
    input  logic [2:0]           operator_code,
    input  logic                 equal,
    output logic                 complete,
    output calc_pkg::calc_word_t display_value
);
    import calc_pkg::*;

    arith_req_t  addsub_req;
    arith_req_t  mul_req;
    arith_resp_t addsub_resp;
    arith_resp_t mul_resp;

    calc_controller u_ctrl (
        .clk           (clk),
        .nRST          (nRST),
        .digit         (digit),
        .digit_valid   (digit_valid),
        .operator_code (operator_code),
        .equal         (equal),
        .addsub_req    (addsub_req),
        .mul_req       (mul_req),
        .addsub_resp   (addsub_resp),
        .mul_resp      (mul_resp),
        .complete      (complete),
        .display_value (display_value)
    );

    add_sub_unit u_addsub (
        .clk  (clk),
        .nRST (nRST),
        .req  (addsub_req),
        .resp (addsub_resp)
    );

    shift_add_multiplier u_mul (
        .clk  (clk),
        .nRST (nRST),
        .req  (mul_req),
        .resp (mul_resp)
    );

endmodule

`default_nettype wire

//--- tb/calc_chk.sv
`timescale 1ns/1ps
`default_nettype none

module calc_chk (
    input logic                  clk,
    input logic                  nRST,
    input calc_pkg::calc_state_e state,
    input calc_pkg::arith_req_t  addsub_req,
    input calc_pkg::arith_req_t  mul_req,
    input calc_pkg::arith_resp_t addsub_resp,
    input calc_pkg::arith_resp_t mul_resp,
    input logic                  complete
);
    import calc_pkg::*;

    localparam logic [4:0] max_wait = 5'd17;

    int         fail_count = 0;
    logic       addsub_pending;
    logic       mul_pending;
    logic [4:0] addsub_age;    // Cycles since start
    logic [4:0] mul_age;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            addsub_pending <= 1'b0;
            addsub_age     <= '0;
            mul_pending    <= 1'b0;
            mul_age        <= '0;
        end else begin
            if (addsub_req.start) begin
                addsub_pending <= 1'b1;
                addsub_age     <= 5'd1;
            end else if (addsub_resp.done) begin
                addsub_pending <= 1'b0;
            end else if (addsub_pending && addsub_age != 5'd31) begin
                addsub_age <= addsub_age + 5'd1;
            end
            if (mul_req.start) begin
                mul_pending <= 1'b1;
                mul_age     <= 5'd1;
            end else if (mul_resp.done) begin
                mul_pending <= 1'b0;
            end else if (mul_pending && mul_age != 5'd31) begin
                mul_age <= mul_age + 5'd1;
            end
        end
    end

    start_exclusive: assert property (@(posedge clk) disable iff (!nRST)
        !(addsub_req.start && mul_req.start))
    else begin
        fail_count++;
        $error("Both arithmetic units started in the same cycle");
    end

    addsub_answers: assert property (@(posedge clk) disable iff (!nRST)
        addsub_pending |-> (addsub_age <= max_wait))
    else begin
        fail_count++;
        $error("Adder did not return done within 17 cycles");
    end

    mul_answers: assert property (@(posedge clk) disable iff (!nRST)
        mul_pending |-> (mul_age <= max_wait))
    else begin
        fail_count++;
        $error("Multiplier did not return done within 17 cycles");
    end

    complete_in_show: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> (state == SHOW))
    else begin
        fail_count++;
        $error("complete high outside SHOW");
    end

endmodule

bind calc_controller calc_chk u_chk (
    .clk         (clk),
    .nRST        (nRST),
    .state       (state),
    .addsub_req  (addsub_req),
    .mul_req     (mul_req),
    .addsub_resp (addsub_resp),
    .mul_resp    (mul_resp),
    .complete    (complete)
);

`default_nettype wire

//--- tb/calc_tb.sv
`timescale 1ns/1ps
`default_nettype none

module calc_tb;
    import calc_pkg::*;

    typedef struct packed {
        calc_word_t  value;       // Expected display_value
        logic [31:0] eq_cycle;    // Edge that sampled equal
        logic        fixed_lat;   // Add and subtract only
    } expect_t;

    localparam int add_latency  = 3;
    localparam int mon_timeout  = 40;
    localparam int stim_timeout = 60;

    logic       clk;
    logic       nRST;
    logic [3:0] digit;
    logic       digit_valid;
    logic [2:0] operator_code;
    logic       equal;
    logic       complete;
    calc_word_t display_value;

    integer     seed;
    int         value_errors = 0;
    int         event_errors = 0;
    int         checks = 0;
    int         results_seen = 0;
    int         cycle = 0;         // Rising edges since time zero
    expect_t    exp_q[$];

    calc_top dut0 (
        .clk           (clk),
        .nRST          (nRST),
        .digit         (digit),
        .digit_valid   (digit_valid),
        .operator_code (operator_code),
        .equal         (equal),
        .complete      (complete),
        .display_value (display_value)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Expected result, wraps modulo 2^16
    function automatic calc_word_t ref_calc(input calc_op_e op, input calc_word_t a,
                                            input calc_word_t b);
        logic [31:0] product;
        product = {16'h0, a} * {16'h0, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            default: return product[15:0];
        endcase
    endfunction

    // Decimal entry keeps the value modulo 2^16
    function automatic calc_word_t to_word(input int unsigned value);
        return value[15:0];
    endfunction

    function automatic logic [2:0] op_key(input calc_op_e op);
        case (op)
            OP_SUB:  return 3'b010;
            OP_MUL:  return 3'b100;
            default: return 3'b001;
        endcase
    endfunction

    // One to five decimal digits
    function automatic int unsigned random_operand();
        int unsigned ndig;
        int unsigned limit;
        int unsigned i;
        ndig  = 1 + ($unsigned($random(seed)) % 5);
        limit = 1;
        for (i = 0; i < ndig; i++) begin
            limit = limit * 10;
        end
        return $unsigned($random(seed)) % limit;
    endfunction

    task automatic check_value(input calc_word_t expected, input calc_word_t actual);
        checks++;
        if (actual !== expected) begin
            $display("[ERROR] display_value expected %h got %h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_latency(input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] complete latency expected %h got %h", expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_quiet(input logic seen);
        if (seen) begin
            $display("ERROR: complete pulsed while no calculation was pending");
            event_errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic press_digit(input logic [3:0] d);
        digit       = d;
        digit_valid = 1'b1;
        next_cycle();
        digit_valid = 1'b0;
        digit       = 4'd0;
        next_cycle();
    endtask

    task automatic press_operator(input logic [2:0] code);
        operator_code = code;
        next_cycle();
        operator_code = 3'b000;
        next_cycle();
    endtask

    task automatic press_equal(output int sampled);
        equal   = 1'b1;
        sampled = cycle + 1;   // Next edge samples it
        next_cycle();
        equal   = 1'b0;
        next_cycle();
    endtask

    task automatic enter_number(input int unsigned value);
        int unsigned rest;
        logic [3:0]  digs[$];
        rest = value;
        do begin
            digs.push_front(4'(rest % 10));
            rest = rest / 10;
        end while (rest != 0);
        foreach (digs[i]) begin
            press_digit(digs[i]);
        end
    endtask

    task automatic expect_result(input calc_op_e op, input calc_word_t a, input calc_word_t b,
                                 input int eq_at);
        expect_t e;
        e.value     = ref_calc(op, a, b);
        e.eq_cycle  = 32'(eq_at);
        e.fixed_lat = (op != OP_MUL);
        exp_q.push_back(e);
    endtask

    task automatic wait_result(input int seen0);
        int waited;
        waited = 0;
        while (results_seen == seen0 && waited < stim_timeout) begin
            next_cycle();
            waited++;
        end
        if (results_seen == seen0) begin
            $display("ERROR: no result was reported within %0d cycles", stim_timeout);
            event_errors++;
        end
        next_cycle();   // Controller back in ENTER_FIRST
    endtask

    task automatic run_calc(input calc_op_e op, input int unsigned a, input int unsigned b,
                            input bit busy_keys);
        int seen0;
        int eq_at;
        int unused_eq;
        seen0 = results_seen;
        enter_number(a);
        press_operator(op_key(op));
        enter_number(b);
        press_equal(eq_at);
        expect_result(op, to_word(a), to_word(b), eq_at);
        if (busy_keys) begin
            press_digit(4'd7);        // Unit still busy
            press_digit(4'd9);
            press_operator(3'b001);
            press_equal(unused_eq);
        end
        wait_result(seen0);
    endtask

    // Compare process
    initial begin : compare
        int      waited;
        expect_t e;
        forever begin
            @(negedge clk);
            if (exp_q.size() != 0) begin
                waited = 0;
                while (!complete && waited < mon_timeout) begin
                    @(negedge clk);
                    waited++;
                end
                e = exp_q.pop_front();
                if (complete) begin
                    check_value(e.value, display_value);
                    if (e.fixed_lat) begin
                        check_latency(add_latency, cycle - int'(e.eq_cycle));
                    end
                end else begin
                    $display("ERROR: complete did not arrive within %0d cycles", mon_timeout);
                    event_errors++;
                end
                results_seen++;
            end else begin
                check_quiet(complete);
            end
        end
    end

    initial begin : stimulus
        int k;
        int seen0;
        int eq_at;
        int unsigned a;
        int unsigned b;
        int assert_errors;
        seed          = 32'hc64b;
        nRST          = 1'b0;
        digit         = 4'd0;
        digit_valid   = 1'b0;
        operator_code = 3'b000;
        equal         = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        nRST = 1'b1;
        next_cycle();

        check_value('0, display_value);
        idle_cycles(20);

        run_calc(OP_ADD, 1234, 8766, 1'b0);
        run_calc(OP_ADD, 30000, 30000, 1'b0);   // Wraps negative
        run_calc(OP_SUB, 25, 1000, 1'b0);
        run_calc(OP_SUB, 99999, 1, 1'b0);       // Operand above 65535
        run_calc(OP_SUB, 0, 65535, 1'b0);

        for (k = 0; k < 50; k++) begin
            a = random_operand();
            b = (k == 0) ? 0 : random_operand();
            run_calc(OP_MUL, a, b, 1'b0);
        end

        // Keys that must not start anything
        seen0 = results_seen;
        press_digit(4'd1);
        press_digit(4'd2);
        press_equal(eq_at);      // No operator yet
        press_operator(3'b000);
        press_operator(3'b011);
        press_operator(3'b111);
        press_digit(4'd10);
        press_digit(4'd15);
        press_digit(4'd3);
        idle_cycles(30);
        press_operator(3'b010);
        press_digit(4'd4);
        press_digit(4'd12);
        press_digit(4'd5);
        press_equal(eq_at);
        expect_result(OP_SUB, 16'sd123, 16'sd45, eq_at);
        wait_result(seen0);

        run_calc(OP_MUL, 321, 40000, 1'b1);   // Long multiply, keys while busy
        run_calc(OP_ADD, 5, 6, 1'b0);
        run_calc(OP_MUL, 255, 255, 1'b0);
        idle_cycles(5);

        assert_errors = dut0.u_ctrl.u_chk.fail_count;
        $display("calc_tb: %0d checks, %0d value errors, %0d event errors, %0d assertion errors",
                 checks, value_errors, event_errors, assert_errors);
        if (value_errors + event_errors + assert_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/calc_pkg.sv
verilog/add_sub_unit.sv
verilog/shift_add_multiplier.sv
verilog/calc_controller.sv
verilog/calc_top.sv
tb/calc_chk.sv
tb/calc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the calculator testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --top-module calc_tb -f vlog.f -o calc_sim \
    || { echo "Verilator build failed"; exit 1; }

./obj_dir/calc_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || { echo "Simulation exited abnormally, see sim.log"; exit 1; }

grep -q -F '*** FAILED ***' sim.log \
    && { echo "Simulation reported failure, see sim.log"; exit 1; } \
    || echo "Simulation passed"
